// File: rtl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// sizing of the 16-bit core

`define DATA_WIDTH 16  // register and memory word
`define REG_COUNT  16  // r0 to r15
`define LINK_REG   15  // jal return address lands here
`define PC_WIDTH   16  // word addressed program counter

`endif

// File: rtl/isaPkg.sv
package isaPkg;

  ////////////////////////////////////////////////////////////
  // opcodes in the top nibble of every instruction
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    RTYPE  = 4'b0000,  // register alu ops
    ANDI   = 4'b0001,
    ORI    = 4'b0010,
    XORI   = 4'b0011,
    SCOND  = 4'b0100,  // write condition bit to rDest
    ADDI   = 4'b0101,
    JRA    = 4'b0110,  // return through link reg
    LOAD   = 4'b0111,
    RTYPE2 = 4'b1000,  // shifts
    SUBI   = 4'b1001,
    STR    = 4'b1010,
    CMPI   = 4'b1011,
    BCOND  = 4'b1100,
    J      = 4'b1101,
    MULTI  = 4'b1110,
    JAL    = 4'b1111
  } opCodeE;

  // function codes of the RTYPE space
  typedef enum logic [3:0] {
    AND  = 4'b0001,
    OR   = 4'b0010,
    XOR  = 4'b0011,
    NOT  = 4'b0100,
    ADD  = 4'b0101,
    ADDU = 4'b0110,  // add without flag update
    SUB  = 4'b1001,
    CMP  = 4'b1011,
    MULT = 4'b1110
  } functCodeE;

  // shift codes of the RTYPE2 space reuse rtype values
  parameter functCodeE LSH  = functCodeE'(4'b0100);  // amount from register
  parameter functCodeE LSHI = functCodeE'(4'b0000);  // low bit is the amount sign
  parameter functCodeE ASH  = functCodeE'(4'b0110);
  parameter functCodeE ASHI = functCodeE'(4'b0011);  // matched on bits 3 to 1

  typedef enum logic [3:0] {
    EQ = 4'd0, NE = 4'd1, CS = 4'd2, CC = 4'd3, HI = 4'd4,
    LS = 4'd5, GT = 4'd6, LE = 4'd7, FS = 4'd8, FC = 4'd9,
    UC = 4'd14  // unconditional
  } condCodeE;

  ////////////////////////////////////////////////////////////
  // one instruction word seen two ways
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    opCodeE     opCode;
    logic [3:0] rDest;  // condition code for bcond and scond
    functCodeE  funct;
    logic [3:0] rSrc;
  } rFormT;

  typedef struct packed {
    opCodeE     opCode;
    logic [3:0] rDest;
    logic [7:0] imm;    // always sign extended
  } iFormT;

  typedef union packed {
    rFormT rView;
    iFormT iView;
  } instrWord;

endpackage

// File: rtl/ctrlPkg.sv
package ctrlPkg;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SUB  = 3'b001,
    ALU_OR   = 3'b010,
    ALU_AND  = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_NOT  = 3'b101,
    ALU_MULT = 3'b110,
    ALU_CMP  = 3'b111
  } aluOpE;

  ////////////////////////////////////////////////////////////
  // decoded control word, one instruction at a time
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic  branch;      // bcond
    logic  jump;        // j and jal
    logic  jumpRa;      // jra
    logic  cfWrite;     // load carry and overflow
    logic  lznWrite;    // load lower, zero, negative
    logic  wbPsr;       // write back condition bit
    logic  rtSrcReg;    // store data from rDest
    logic  wbSrc;       // execution result, low for load data
    logic  memSrc;      // alu result, low for shifter
    logic  shiftSrc;    // register shift amount
    logic  aluSrcB;     // register operand b, low for immediate
    logic  regWriteEn;
    logic  raWrite;     // link write to LINK_REG
    logic  shiftType;   // arithmetic fill
    logic  memWrite;
    logic  enRam;       // data memory enable
    aluOpE aluOp;
  } ctrlSignals;

  typedef struct packed {
    logic c;  // carry or borrow
    logic l;  // lower, unsigned
    logic f;  // signed overflow
    logic z;
    logic n;  // signed compare
  } psrFlags;

endpackage

// File: rtl/logicController.sv
`timescale 1ns/10ps

module logicController (
  input  logic                clk,
  input  logic                reset,
  input  isaPkg::opCodeE      opCode,
  input  isaPkg::functCodeE   functionCode,
  output ctrlPkg::ctrlSignals ctrl,
  output logic                pcEn
);
  import isaPkg::*;
  import ctrlPkg::*;

  typedef enum logic {EX, MEM} stateE;

  stateE      state;      // present state
  stateE      nextState;
  logic       memOp;      // load or store presented
  ctrlSignals dec;        // raw decode before state gating

  // shape shared by every alu op that writes back
  function automatic ctrlSignals aluWb(aluOpE op, logic regB);
    ctrlSignals c;
    c            = '0;
    c.wbSrc      = 1'b1;  // execution result
    c.memSrc     = 1'b1;  // alu, not shifter
    c.regWriteEn = 1'b1;
    c.aluSrcB    = regB;
    c.aluOp      = op;
    return c;
  endfunction

  assign memOp = (opCode == LOAD) || (opCode == STR);

  ////////////////////////////////////////////////////////////
  // EX / MEM sequencing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= EX;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = EX;
    if ((state == EX) && memOp)
      nextState = MEM;  // one extra cycle for the data access
  end

  // retire on single cycle ops and at the end of MEM
  assign pcEn = !reset && ((state == MEM) || !memOp);

  ////////////////////////////////////////////////////////////
  // opcode and function decode
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    dec = '0;
    case (opCode)
      ADDI:
      begin
        dec         = aluWb(ALU_ADD, 1'b0);
        dec.cfWrite = 1'b1;
      end
      SUBI:
      begin
        dec         = aluWb(ALU_SUB, 1'b0);
        dec.cfWrite = 1'b1;
      end
      MULTI: dec = aluWb(ALU_MULT, 1'b0);  // flags untouched
      CMPI:
      begin
        dec            = aluWb(ALU_CMP, 1'b0);
        dec.regWriteEn = 1'b0;  // flags only
        dec.lznWrite   = 1'b1;
      end
      ANDI:  dec = aluWb(ALU_AND, 1'b0);
      ORI:   dec = aluWb(ALU_OR, 1'b0);
      XORI:  dec = aluWb(ALU_XOR, 1'b0);
      BCOND: dec.branch = 1'b1;
      J:     dec.jump = 1'b1;
      JAL:
      begin
        dec.jump       = 1'b1;
        dec.raWrite    = 1'b1;  // pc+1 to link reg
        dec.regWriteEn = 1'b1;
      end
      JRA:   dec.jumpRa = 1'b1;
      RTYPE:
      begin
        case (functionCode)
          ADDU: dec = aluWb(ALU_ADD, 1'b1);
          MULT: dec = aluWb(ALU_MULT, 1'b1);
          AND:  dec = aluWb(ALU_AND, 1'b1);
          OR:   dec = aluWb(ALU_OR, 1'b1);
          XOR:  dec = aluWb(ALU_XOR, 1'b1);
          NOT:  dec = aluWb(ALU_NOT, 1'b1);  // inverts rSrc
          SUB:
          begin
            dec         = aluWb(ALU_SUB, 1'b1);
            dec.cfWrite = 1'b1;
          end
          CMP:
          begin
            dec            = aluWb(ALU_CMP, 1'b1);
            dec.regWriteEn = 1'b0;
            dec.lznWrite   = 1'b1;
          end
          default:  // ADD and unused codes
          begin
            dec         = aluWb(ALU_ADD, 1'b1);
            dec.cfWrite = 1'b1;
          end
        endcase
      end
      RTYPE2:
      begin
        dec.wbSrc      = 1'b1;  // memSrc low picks shifter
        dec.regWriteEn = 1'b1;
        casez (functionCode)
          LSH:     dec.shiftSrc = 1'b1;
          ASH:
          begin
            dec.shiftSrc  = 1'b1;
            dec.shiftType = 1'b1;
          end
          4'b000?: dec.shiftSrc = 1'b0;   // lshi with immediate amount
          4'b001?: dec.shiftType = 1'b1;  // ashi with immediate amount
          default: dec.shiftSrc = 1'b1;
        endcase
      end
      LOAD:
      begin
        dec.enRam      = 1'b1;
        dec.regWriteEn = 1'b1;  // wbSrc low selects load data
      end
      STR:
      begin
        dec.enRam    = 1'b1;
        dec.memWrite = 1'b1;
        dec.rtSrcReg = 1'b1;    // store data is reg[rDest]
      end
      SCOND:
      begin
        dec.regWriteEn = 1'b1;
        dec.wbPsr      = 1'b1;
      end
      default:
      begin
        dec.wbSrc  = 1'b1;
        dec.memSrc = 1'b1;
      end
    endcase
  end

  // strobes follow the state machine
  always_comb
  begin
    ctrl            = dec;
    ctrl.memWrite   = dec.memWrite && pcEn && (state == MEM);  // one cycle store strobe
    ctrl.regWriteEn = dec.regWriteEn && pcEn;                  // loads write at end of MEM
    ctrl.enRam      = dec.enRam && !reset;
  end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module regFile (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [$clog2(`REG_COUNT)-1:0] rdAddrA,
  input  logic [$clog2(`REG_COUNT)-1:0] rdAddrB,
  input  logic [$clog2(`REG_COUNT)-1:0] wrAddr,
  input  logic                          wrEn,
  input  logic [`DATA_WIDTH-1:0]        wrData,
  output logic [`DATA_WIDTH-1:0]        rdA,
  output logic [`DATA_WIDTH-1:0]        rdB
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  assign rdA = regs[rdAddrA];  // async read
  assign rdB = regs[rdAddrB];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wrEn)
      regs[wrAddr] <= wrData;
  end

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module aluUnit (
  input  logic [`DATA_WIDTH-1:0] opA,       // reg[rDest]
  input  logic [`DATA_WIDTH-1:0] opB,       // reg[rSrc] or immediate
  input  ctrlPkg::aluOpE         aluOp,
  output logic [`DATA_WIDTH-1:0] result,
  output ctrlPkg::psrFlags       aluFlags
);
  import ctrlPkg::*;

  localparam int msb = `DATA_WIDTH - 1;

  logic [`DATA_WIDTH:0] sum;   // carry out on top
  logic [`DATA_WIDTH:0] diff;  // borrow on top

  assign sum  = {1'b0, opA} + {1'b0, opB};
  assign diff = {1'b0, opA} - {1'b0, opB};

  always_comb
  begin
    case (aluOp)
      ALU_ADD:  result = sum[msb:0];
      ALU_SUB:  result = diff[msb:0];
      ALU_OR:   result = opA | opB;
      ALU_AND:  result = opA & opB;
      ALU_XOR:  result = opA ^ opB;
      ALU_NOT:  result = ~opB;
      ALU_MULT: result = opA * opB;  // low half of product
      default:  result = diff[msb:0];  // cmp result goes nowhere
    endcase
  end

  ////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (aluOp == ALU_SUB)
    begin
      aluFlags.c = diff[`DATA_WIDTH];  // borrow
      aluFlags.f = (opA[msb] != opB[msb]) && (diff[msb] != opA[msb]);
    end
    else
    begin
      aluFlags.c = sum[`DATA_WIDTH];
      aluFlags.f = (opA[msb] == opB[msb]) && (sum[msb] != opA[msb]);
    end
    aluFlags.z = (opA == opB);                    // compare against rDest
    aluFlags.l = (opB > opA);                     // operand unsigned greater
    aluFlags.n = ($signed(opB) > $signed(opA));   // operand signed greater
  end

endmodule

// File: rtl/shiftUnit.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module shiftUnit (
  input  logic [`DATA_WIDTH-1:0] src,     // reg[rDest]
  input  logic signed [4:0]      amount,  // positive shifts left
  input  logic                   arith,   // sign fill on right shifts
  output logic [`DATA_WIDTH-1:0] result
);

  logic [4:0] mag;  // right shift distance, 16 for -16

  assign mag = -amount;

  always_comb
  begin
    if (!amount[4])
      result = src << amount[3:0];
    else if (arith)
      result = $signed(src) >>> mag;
    else
      result = src >> mag;  // zero fill
  end

endmodule

// File: rtl/psrUnit.sv
`timescale 1ns/10ps

module psrUnit (
  input  logic             clk,
  input  logic             reset,
  input  ctrlPkg::psrFlags aluFlags,
  input  logic             cfWrite,
  input  logic             lznWrite,
  input  isaPkg::condCodeE cond,      // from the rDest field
  output logic             condTrue
);
  import isaPkg::*;
  import ctrlPkg::*;

  psrFlags flags;  // held status

  always_ff @(posedge clk)
  begin
    if (reset)
      flags <= '0;
    else
    begin
      if (cfWrite)
      begin
        flags.c <= aluFlags.c;
        flags.f <= aluFlags.f;
      end
      if (lznWrite)
      begin
        flags.l <= aluFlags.l;
        flags.z <= aluFlags.z;
        flags.n <= aluFlags.n;
      end
    end
  end

  // condition evaluation against held flags
  always_comb
  begin
    case (cond)
      EQ:      condTrue = flags.z;
      NE:      condTrue = !flags.z;
      CS:      condTrue = flags.c;
      CC:      condTrue = !flags.c;
      HI:      condTrue = flags.l;
      LS:      condTrue = !flags.l;
      GT:      condTrue = flags.n;
      LE:      condTrue = !flags.n;
      FS:      condTrue = flags.f;
      FC:      condTrue = !flags.f;
      UC:      condTrue = 1'b1;
      default: condTrue = 1'b0;  // unused codes never hold
    endcase
  end

endmodule

// File: rtl/pcUnit.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module pcUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pcEn,        // retire strobe
  input  logic                 branch,
  input  logic                 jump,
  input  logic                 jumpRa,
  input  logic                 condTrue,
  input  logic [`PC_WIDTH-1:0] disp,        // sign extended imm
  input  logic [`PC_WIDTH-1:0] jumpTarget,  // reg[rSrc]
  input  logic [`PC_WIDTH-1:0] linkTarget,  // reg[LINK_REG]
  output logic [`PC_WIDTH-1:0] pc
);

  logic [`PC_WIDTH-1:0] pcNext;

  always_comb
  begin
    if (branch && condTrue)
      pcNext = pc + disp;  // relative branch
    else if (jump)
      pcNext = jumpTarget;
    else if (jumpRa)
      pcNext = linkTarget;
    else
      pcNext = pc + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (pcEn)
      pc <= pcNext;  // holds through EX of load and store
  end

endmodule

// File: rtl/resultSelect.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module resultSelect (
  input  logic [`DATA_WIDTH-1:0]        aluResult,
  input  logic [`DATA_WIDTH-1:0]        shiftResult,
  input  logic [`DATA_WIDTH-1:0]        memRdata,
  input  logic [`DATA_WIDTH-1:0]        pcLink,     // pc+1
  input  logic                          condTrue,
  input  ctrlPkg::ctrlSignals           ctrl,
  input  logic [$clog2(`REG_COUNT)-1:0] rDest,
  output logic [`DATA_WIDTH-1:0]        wbData,
  output logic [$clog2(`REG_COUNT)-1:0] wbAddr
);

  localparam int addrBits = $clog2(`REG_COUNT);
  localparam logic [addrBits-1:0] linkAddr = addrBits'(`LINK_REG);

  logic [`DATA_WIDTH-1:0] exResult;  // alu or shifter

  assign exResult = ctrl.memSrc ? aluResult : shiftResult;

  always_comb
  begin
    if (ctrl.wbPsr)
      wbData = {{(`DATA_WIDTH-1){1'b0}}, condTrue};  // scond writes 0 or 1
    else if (ctrl.raWrite)
      wbData = pcLink;
    else if (ctrl.wbSrc)
      wbData = exResult;
    else
      wbData = memRdata;  // load
  end

  assign wbAddr = ctrl.raWrite ? linkAddr : rDest;

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module cpuTop (
  input  logic                   clk,
  input  logic                   reset,
  input  isaPkg::instrWord       instr,
  input  logic [`DATA_WIDTH-1:0] memRdata,
  output logic [`PC_WIDTH-1:0]   pc,
  output logic [`DATA_WIDTH-1:0] memAddr,
  output logic [`DATA_WIDTH-1:0] memWdata,
  output logic                   memWrite,
  output logic                   memEn
);
  import isaPkg::*;
  import ctrlPkg::*;

  localparam int addrBits = $clog2(`REG_COUNT);
  localparam logic [addrBits-1:0] linkAddr = addrBits'(`LINK_REG);

  ctrlSignals             ctrl;
  logic                   pcEn;
  psrFlags                aluFlags;
  logic                   condTrue;
  logic [addrBits-1:0]    rdAddrA;
  logic [addrBits-1:0]    wbAddr;
  logic [`DATA_WIDTH-1:0] rdA;
  logic [`DATA_WIDTH-1:0] rdB;
  logic [`DATA_WIDTH-1:0] immExt;
  logic [`DATA_WIDTH-1:0] aluOpB;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic [`DATA_WIDTH-1:0] shiftResult;
  logic [`DATA_WIDTH-1:0] pcLink;
  logic [`DATA_WIDTH-1:0] wbData;
  logic [4:0]             shiftAmt;
  logic [`PC_WIDTH-1:0]   disp;

  ////////////////////////////////////////////////////////////
  // operand routing
  ////////////////////////////////////////////////////////////
  assign rdAddrA  = ctrl.jumpRa ? linkAddr : instr.rView.rDest;  // jra reads the link reg
  assign immExt   = {{(`DATA_WIDTH-8){instr.iView.imm[7]}}, instr.iView.imm};
  assign disp     = {{(`PC_WIDTH-8){instr.iView.imm[7]}}, instr.iView.imm};
  assign aluOpB   = ctrl.aluSrcB ? rdB : immExt;
  assign shiftAmt = ctrl.shiftSrc ? rdB[4:0] : instr.iView.imm[4:0];  // funct lsb and rSrc
  assign pcLink   = `DATA_WIDTH'(pc + 1'b1);

  // data memory side
  assign memAddr  = rdB;                           // reg[rSrc]
  assign memWdata = ctrl.rtSrcReg ? rdA : rdB;     // store data from rDest
  assign memWrite = ctrl.memWrite;
  assign memEn    = ctrl.enRam;

  logicController u_ctrl (
    .clk(clk), .reset(reset),
    .opCode(instr.rView.opCode), .functionCode(instr.rView.funct),
    .ctrl(ctrl), .pcEn(pcEn)
  );

  regFile u_regs (
    .clk(clk), .reset(reset),
    .rdAddrA(rdAddrA), .rdAddrB(instr.rView.rSrc),
    .wrAddr(wbAddr), .wrEn(ctrl.regWriteEn), .wrData(wbData),
    .rdA(rdA), .rdB(rdB)
  );

  aluUnit u_alu (
    .opA(rdA), .opB(aluOpB), .aluOp(ctrl.aluOp),
    .result(aluResult), .aluFlags(aluFlags)
  );

  shiftUnit u_shift (
    .src(rdA), .amount(shiftAmt), .arith(ctrl.shiftType), .result(shiftResult)
  );

  psrUnit u_psr (
    .clk(clk), .reset(reset), .aluFlags(aluFlags),
    .cfWrite(ctrl.cfWrite), .lznWrite(ctrl.lznWrite),
    .cond(condCodeE'(instr.rView.rDest)), .condTrue(condTrue)
  );

  pcUnit u_pc (
    .clk(clk), .reset(reset), .pcEn(pcEn),
    .branch(ctrl.branch), .jump(ctrl.jump), .jumpRa(ctrl.jumpRa), .condTrue(condTrue),
    .disp(disp), .jumpTarget(`PC_WIDTH'(rdB)), .linkTarget(`PC_WIDTH'(rdA)),
    .pc(pc)
  );

  resultSelect u_wb (
    .aluResult(aluResult), .shiftResult(shiftResult), .memRdata(memRdata),
    .pcLink(pcLink), .condTrue(condTrue), .ctrl(ctrl), .rDest(instr.rView.rDest),
    .wbData(wbData), .wbAddr(wbAddr)
  );

endmodule

// File: tests/cpuTb.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module cpuTb;
  import isaPkg::*;

  localparam logic [15:0] haltWord = {BCOND, UC, 8'h00};  // branch to self
  localparam int timeoutCycles = 3000;

  logic                   clk;
  logic                   reset;
  instrWord               instr;
  logic [`DATA_WIDTH-1:0] memRdata;
  logic [`PC_WIDTH-1:0]   pc;
  logic [`DATA_WIDTH-1:0] memAddr;
  logic [`DATA_WIDTH-1:0] memWdata;
  logic                   memWrite;
  logic                   memEn;

  logic [15:0] prog [256];          // instruction memory
  logic [15:0] dmem [256];          // data memory
  int          progLen;             // next free program slot
  logic [15:0] mreg [`REG_COUNT];   // model registers
  logic        mc, ml, mf, mz, mn;  // model flags
  logic [15:0] expAddr [$];
  logic [15:0] expData [$];
  logic [15:0] gotAddr [$];
  logic [15:0] gotData [$];
  logic [15:0] pcTrace [$];         // pc of every executed cycle
  int          enCycles;            // cycles with memEn high
  string       curTest;
  int          testErrors;
  int          errorCount;
  int          checkCount;
  int          testsRun;
  int          testsFailed;

  cpuTop u_dut (
    .clk(clk), .reset(reset), .instr(instr), .memRdata(memRdata),
    .pc(pc), .memAddr(memAddr), .memWdata(memWdata), .memWrite(memWrite), .memEn(memEn)
  );

  always #4 clk = ~clk;  // 8 ns period

  ////////////////////////////////////////////////////////////
  // memory side of the core
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    memRdata <= dmem[memAddr[7:0]];  // address held through EX and MEM
    instr    <= prog[pc[7:0]];
  end

  always @(posedge clk)
  begin
    if (!reset)
    begin
      pcTrace.push_back(pc);  // value before this edge
      if (memEn)
        enCycles++;
      if (memWrite)
      begin
        gotAddr.push_back(memAddr);
        gotData.push_back(memWdata);
        dmem[memAddr[7:0]] = memWdata;
      end
    end
  end

  task automatic check(input string what, input logic [31:0] expVal,
                       input logic [31:0] actVal);
    checkCount++;
    if (actVal !== expVal)
    begin
      $display("error in test %s: %s expected %h actual %h", curTest, what, expVal, actVal);
      testErrors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model of registers and flags
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] addModel(input logic [15:0] a, input logic [15:0] b);
    int s;
    s  = int'($signed(a)) + int'($signed(b));
    mc = ({16'h0, a} + {16'h0, b}) > 32'hffff;  // carry out of bit 15
    mf = (s > 32767) || (s < -32768);
    return a + b;
  endfunction

  function automatic logic [15:0] subModel(input logic [15:0] a, input logic [15:0] b);
    int s;
    s  = int'($signed(a)) - int'($signed(b));
    mc = a < b;  // borrow
    mf = (s > 32767) || (s < -32768);
    return a - b;
  endfunction

  function automatic void cmpModel(input logic [15:0] a, input logic [15:0] b);
    mz = (a == b);
    ml = (b > a);                    // operand unsigned greater
    mn = ($signed(b) > $signed(a));  // operand signed greater
  endfunction

  function automatic logic [15:0] shiftModel(input logic [15:0] a, input logic [3:0] fn,
                                              input logic [3:0] rs, input logic [15:0] b);
    logic signed [4:0] amt;
    logic              arith;
    logic [31:0]       wide;
    int                k;
    amt   = (fn == LSH || fn == ASH) ? b[4:0] : {fn[0], rs};
    arith = (fn == ASH) || (fn[3:1] == 3'b001);
    if (amt >= 0)
      return a << amt;
    k    = -int'(amt);
    wide = arith ? {{16{a[15]}}, a} : {16'h0, a};  // fill source above the word
    wide = wide >> k;
    return wide[15:0];
  endfunction

  function automatic logic condModel(input logic [3:0] c);
    case (c)
      4'd0:    return mz;
      4'd1:    return !mz;
      4'd2:    return mc;
      4'd3:    return !mc;
      4'd4:    return ml;
      4'd5:    return !ml;
      4'd6:    return mn;
      4'd7:    return !mn;
      4'd8:    return mf;
      4'd9:    return !mf;
      4'd14:   return 1'b1;  // uc
      default: return 1'b0;
    endcase
  endfunction

  // place one instruction and apply it to the model
  task automatic issue(input opCodeE op, input logic [3:0] rd, input logic [7:0] low);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [3:0]  fn;
    a   = mreg[rd];
    b   = mreg[low[3:0]];
    imm = {{8{low[7]}}, low};
    fn  = low[7:4];
    prog[progLen] = {op, rd, low};
    case (op)
      ADDI:   mreg[rd] = addModel(a, imm);
      SUBI:   mreg[rd] = subModel(a, imm);
      MULTI:  mreg[rd] = a * imm;
      CMPI:   cmpModel(a, imm);
      ANDI:   mreg[rd] = a & imm;
      ORI:    mreg[rd] = a | imm;
      XORI:   mreg[rd] = a ^ imm;
      RTYPE:
      begin
        case (fn)
          ADDU:    mreg[rd] = a + b;  // no flags
          SUB:     mreg[rd] = subModel(a, b);
          MULT:    mreg[rd] = a * b;
          CMP:     cmpModel(a, b);
          AND:     mreg[rd] = a & b;
          OR:      mreg[rd] = a | b;
          XOR:     mreg[rd] = a ^ b;
          NOT:     mreg[rd] = ~b;
          default: mreg[rd] = addModel(a, b);
        endcase
      end
      RTYPE2: mreg[rd] = shiftModel(a, fn, low[3:0], b);
      SCOND:  mreg[rd] = {15'h0, condModel(rd)};
      LOAD:   mreg[rd] = dmem[b[7:0]];
      STR:
      begin
        expAddr.push_back(b);
        expData.push_back(a);
      end
      JAL:    mreg[`LINK_REG] = 16'(progLen + 1);
      default: ;  // branches and plain jumps write no register
    endcase
    progLen++;
  endtask

  task automatic issueR(input opCodeE op, input logic [3:0] rd, input functCodeE fn,
                        input logic [3:0] rs);
    issue(op, rd, {fn, rs});
  endtask

  function automatic logic [7:0] randByte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // random 16-bit word built from two immediates
  task automatic loadRandom(input logic [3:0] r);
    issueR(RTYPE, r, XOR, r);
    issue(ADDI, r, randByte());
    issue(RTYPE2, r, 8'h08);  // lshi by 8
    issue(ADDI, r, randByte());
  endtask

  task automatic copyReg(input logic [3:0] dst, input logic [3:0] src);
    issueR(RTYPE, dst, XOR, dst);
    issueR(RTYPE, dst, ADDU, src);
  endtask

  task automatic storeOut(input logic [3:0] r);
    issue(STR, r, 8'h0d);    // r13 walks the output area
    issue(ADDI, 4'd13, 8'h01);
  endtask

  function automatic int countPc(input logic [15:0] addr);
    int n;
    n = 0;
    foreach (pcTrace[i])
      if (pcTrace[i] == addr)
        n++;
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // test sequencing
  ////////////////////////////////////////////////////////////
  task automatic startTest(input string name);
    curTest    = name;
    testErrors = 0;
    @(negedge clk);
    reset <= 1'b1;
    for (int i = 0; i < 256; i++)
      prog[i] = haltWord;
    for (int i = 0; i < `REG_COUNT; i++)
      mreg[i] = '0;
    {mc, ml, mf, mz, mn} = '0;
    progLen = 0;
    expAddr.delete();
    expData.delete();
  endtask

  task automatic runProgram(input int endAddr);
    int cycles;
    repeat (10)
    begin
      @(negedge clk);
      check("pc in reset", 0, pc);
      check("memWrite in reset", 0, memWrite);
      check("memEn in reset", 0, memEn);
    end
    pcTrace.delete();
    gotAddr.delete();
    gotData.delete();
    enCycles = 0;
    reset <= 1'b0;
    cycles = 0;
    while (pc !== endAddr && cycles < timeoutCycles)
    begin
      @(negedge clk);
      cycles++;
    end
    if (pc !== endAddr)
    begin
      $display("test %s timed out, pc stuck at %0d and never reached %0d", curTest, pc, endAddr);
      testErrors++;
    end
  endtask

  task automatic finishTest();
    int n;
    check("store count", expAddr.size(), gotAddr.size());
    n = (expAddr.size() < gotAddr.size()) ? expAddr.size() : gotAddr.size();
    for (int i = 0; i < n; i++)
    begin
      check($sformatf("store %0d address", i), expAddr[i], gotAddr[i]);
      check($sformatf("store %0d data", i), expData[i], gotData[i]);
    end
    testsRun++;
    errorCount += testErrors;
    if (testErrors == 0)
      $display("test %s passed", curTest);
    else
    begin
      $display("test %s failed with %0d errors", curTest, testErrors);
      testsFailed++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic resetTest();
    startTest("reset");
    issue(ADDI, 4'd1, randByte());
    storeOut(4'd1);
    runProgram(progLen);
    check("first fetch", 0, (pcTrace.size() > 0) ? pcTrace[0] : 16'hffff);
    finishTest();
  endtask

  task automatic aluTest();
    functCodeE fnList [8];
    opCodeE    opList [6];
    fnList = '{ADD, ADDU, SUB, MULT, AND, OR, XOR, NOT};
    opList = '{ADDI, SUBI, MULTI, ANDI, ORI, XORI};
    startTest("alu");
    loadRandom(4'd1);
    loadRandom(4'd2);
    foreach (fnList[k])
    begin
      copyReg(4'd3, 4'd1);
      issueR(RTYPE, 4'd3, fnList[k], 4'd2);
      storeOut(4'd3);
    end
    foreach (opList[k])
    begin
      copyReg(4'd3, 4'd1);
      issue(opList[k], 4'd3, randByte());  // sign extended imm
      storeOut(4'd3);
    end
    runProgram(progLen);
    finishTest();
  endtask

  task automatic shiftTest();
    logic [4:0] amts [6];
    logic [7:0] regAmts [2];
    amts    = '{5'd3, 5'b11011, 5'd15, 5'b10000, 5'b11111, 5'd1};  // 3 -5 15 -16 -1 1
    regAmts = '{8'hfd, 8'h06};                                    // -3 and 6
    startTest("shift");
    loadRandom(4'd1);
    loadRandom(4'd2);
    issue(ORI, 4'd1, 8'h80);  // zero fill must differ from sign fill
    issue(ORI, 4'd2, 8'h80);  // negative, so sign fill shows
    foreach (amts[k])
    begin
      copyReg(4'd3, 4'd1);
      issue(RTYPE2, 4'd3, {3'b000, amts[k]});  // lshi
      storeOut(4'd3);
      copyReg(4'd3, 4'd2);
      issue(RTYPE2, 4'd3, {3'b001, amts[k]});  // ashi
      storeOut(4'd3);
    end
    foreach (regAmts[k])
    begin
      issueR(RTYPE, 4'd5, XOR, 4'd5);
      issue(ADDI, 4'd5, regAmts[k]);
      copyReg(4'd3, 4'd2);
      issueR(RTYPE2, 4'd3, LSH, 4'd5);
      storeOut(4'd3);
      copyReg(4'd3, 4'd2);
      issueR(RTYPE2, 4'd3, ASH, 4'd5);
      storeOut(4'd3);
    end
    runProgram(progLen);
    finishTest();
  endtask

  task automatic condTest();
    logic [3:0] conds [11];
    int         brAddr;
    int         idx;
    conds = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd14};
    startTest("conditions");
    for (int round = 0; round < 3; round++)
    begin
      loadRandom(4'd10);
      loadRandom(4'd11);
      if (round == 2)
        copyReg(4'd11, 4'd10);  // equal operands
      issueR(RTYPE, 4'd10, CMP, 4'd11);
      copyReg(4'd12, 4'd10);
      issueR(RTYPE, 4'd12, functCodeE'((round == 1) ? ADD : SUB), 4'd11);  // carry, overflow
      foreach (conds[k])
        issue(SCOND, conds[k], 8'h00);  // scond writes r[cond]
      foreach (conds[k])
        storeOut(conds[k]);
    end
    issueR(RTYPE, 4'd10, CMP, 4'd10);  // z set
    brAddr = progLen;
    issue(BCOND, EQ, 8'h02);  // taken over the trap
    progLen++;                // halt trap
    issue(BCOND, NE, 8'h05);  // not taken
    issue(ORI, 4'd0, 8'h00);  // fall through lands here
    runProgram(progLen);
    idx = -1;
    foreach (pcTrace[i])
      if (idx < 0 && pcTrace[i] == brAddr)
        idx = i;
    if (idx < 0 || idx + 2 >= pcTrace.size())
    begin
      $display("test %s: the branch at %0d was never executed", curTest, brAddr);
      testErrors++;
    end
    else
    begin
      check("pc after taken branch", brAddr + 2, pcTrace[idx + 1]);
      check("pc after untaken branch", brAddr + 3, pcTrace[idx + 2]);
    end
    finishTest();
  endtask

  task automatic memTest();
    int ldAddr;
    int stAddr;
    startTest("memory");
    issue(ADDI, 4'd1, 8'd100);
    issue(ADDI, 4'd3, 8'd120);
    ldAddr = progLen;
    issue(LOAD, 4'd2, 8'h01);  // r2 = mem[r1]
    stAddr = progLen;
    issue(STR, 4'd2, 8'h03);   // mem[r3] = r2
    issue(ADDI, 4'd1, 8'h01);
    issue(LOAD, 4'd4, 8'h01);
    issue(ADDI, 4'd3, 8'h01);
    issue(STR, 4'd4, 8'h03);
    runProgram(progLen);
    check("cycles at load", 2, countPc(ldAddr));
    check("cycles at store", 2, countPc(stAddr));
    check("cycles at addi", 1, countPc(0));
    check("memEn cycles", 8, enCycles);  // EX and MEM of two loads and two stores
    finishTest();
  endtask

  task automatic jumpTest();
    logic [15:0] expTrace [11];
    expTrace = '{16'd0, 16'd1, 16'd2, 16'd3, 16'd7, 16'd8, 16'd4, 16'd4, 16'd5, 16'd5, 16'd6};
    startTest("jumps");
    issue(ADDI, 4'd1, 8'd7);    // subroutine entry
    issue(ADDI, 4'd2, 8'd11);   // exit address
    issue(ADDI, 4'd13, 8'd32);
    issue(JAL, 4'd0, 8'h01);
    progLen = 7;                // subroutine
    issue(ADDI, 4'd5, 8'd77);
    issue(JRA, 4'd0, 8'h00);
    progLen = 4;                // return lands here
    issue(STR, 4'd15, 8'h0d);   // link value
    issue(STR, 4'd5, 8'h0d);
    issue(J, 4'd0, 8'h02);
    runProgram(11);
    check("trace length", 1, pcTrace.size() >= 11);
    foreach (expTrace[i])
      if (i < pcTrace.size())
        check($sformatf("pc of cycle %0d", i), expTrace[i], pcTrace[i]);
    finishTest();
  endtask

  initial
  begin
    void'($urandom(32'h8fa9_3224));
    clk         = 1'b0;
    reset       = 1'b1;
    instr       = haltWord;
    memRdata    = '0;
    enCycles    = 0;
    errorCount  = 0;
    checkCount  = 0;
    testsRun    = 0;
    testsFailed = 0;
    for (int i = 0; i < 256; i++)
    begin
      prog[i] = haltWord;
      dmem[i] = 16'($urandom);
    end
    resetTest();
    aluTest();
    shiftTest();
    condTest();
    memTest();
    jumpTest();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checkCount, errorCount);
    if (errorCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/logicController.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/shiftUnit.sv
rtl/psrUnit.sv
rtl/pcUnit.sv
rtl/resultSelect.sv
rtl/cpuTop.sv
tests/cpuTb.sv
